// File: source/apb_string_regs.sv
`timescale 1ns/1ps
/*
 * APB slave, zero wait states, word aligned accesses only
 * unmapped addresses give pslverr, writes there are ignored
 * a start needs an idle sender and a length of 1 to 16
 * a frame arriving while rx_ready is set is dropped, rx_dropped flags it
 */
module apb_string_regs import str_link_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_n,
	input apb_req_t apb,
	output apb_rsp_t apb_rsp,
	output tx_job_t tx_job,
	output logic tx_start,
	input logic tx_busy,
	input rx_frame_t rx_frame,
	input logic frame_vld
);

	localparam logic [7:0] ADDR_CTRL = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;
	localparam logic [7:0] ADDR_RX_ACK = 8'h08;

	logic access;
	logic wr_en;
	logic rd_en;
	logic hit_ctrl;
	logic hit_status;
	logic hit_ack;
	logic hit_tx;
	logic hit_rx;
	logic [3:0] word_base;
	logic start_ok;
	logic ack_wr;
	logic rx_take;
	logic [31:0] status_word;
	str_buf_t tx_buf;
	str_len_t tx_len;
	rx_frame_t rx_buf;
	logic rx_ready;
	logic rx_dropped;

	assign access = apb.psel & apb.penable;
	assign wr_en = access & apb.pwrite;
	assign rd_en = access & ~apb.pwrite;

	assign hit_ctrl = (apb.paddr == ADDR_CTRL);
	assign hit_status = (apb.paddr == ADDR_STATUS);
	assign hit_ack = (apb.paddr == ADDR_RX_ACK);
	// 0x10..0x1c and 0x20..0x2c
	assign hit_tx = (apb.paddr[7:4] == 4'h1) & (apb.paddr[1:0] == 2'b00);
	assign hit_rx = (apb.paddr[7:4] == 4'h2) & (apb.paddr[1:0] == 2'b00);

	// first byte of the addressed word
	assign word_base = {apb.paddr[3:2], 2'b00};

	assign start_ok = wr_en & hit_ctrl & apb.pwdata[8] & ~tx_busy & ~tx_start
		& (apb.pwdata[4:0] != 5'd0) & (apb.pwdata[4:0] <= str_len_t'(STR_MAX_BYTES));
	assign ack_wr = wr_en & hit_ack;
	// an ack in the same cycle frees the slot
	assign rx_take = frame_vld & (~rx_ready | ack_wr);

	assign tx_job.data = tx_buf;
	assign tx_job.len = tx_len;

	assign status_word = {19'd0, rx_buf.len, 4'd0,
		rx_dropped, rx_buf.overflow, rx_ready, tx_busy};

	always_comb begin
		apb_rsp.prdata = '0;
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access & ~(hit_ctrl | hit_status | hit_ack | hit_tx | hit_rx);
		if (rd_en) begin
			if (hit_status)
				apb_rsp.prdata = status_word;
			else if (hit_tx)
				apb_rsp.prdata = tx_buf[word_base +: 4];
			else if (hit_rx)
				apb_rsp.prdata = rx_buf.data[word_base +: 4];
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_buf <= '0;
			tx_len <= '0;
			tx_start <= 1'b0;
			rx_buf <= '0;
			rx_ready <= 1'b0;
			rx_dropped <= 1'b0;
		end else begin
			tx_start <= start_ok;
			if (start_ok)
				tx_len <= apb.pwdata[4:0];
			if (wr_en && hit_tx)
				tx_buf[word_base +: 4] <= apb.pwdata;
			if (ack_wr) begin
				rx_ready <= 1'b0;
				rx_dropped <= 1'b0;
			end
			if (rx_take) begin
				rx_buf <= rx_frame;
				rx_ready <= 1'b1;
			end else if (frame_vld) begin
				rx_dropped <= 1'b1;
			end
		end
	end

endmodule

// File: source/frame_receiver.sv
`timescale 1ns/1ps
/*
 * finds "&&" payload "&&" in the byte stream
 * keeps the first 16 payload bytes, longer frames set overflow
 * a lone marker inside a payload drops the frame
 * rx_frame is rebuilt in place, valid when frame_vld pulses
 */
module frame_receiver import str_link_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic [7:0] rx_byte,
	input logic rx_vld,
	output rx_frame_t rx_frame,
	output logic frame_vld
);

	localparam logic [1:0] R_HUNT = 2'd0;
	localparam logic [1:0] R_OPEN = 2'd1;
	localparam logic [1:0] R_PAYLOAD = 2'd2;
	localparam logic [1:0] R_CLOSE = 2'd3;

	logic [1:0] state;
	logic is_mark;
	logic buf_full;

	assign is_mark = (rx_byte == FRAME_MARK);
	assign buf_full = (rx_frame.len == str_len_t'(STR_MAX_BYTES));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= R_HUNT;
			rx_frame <= '0;
			frame_vld <= 1'b0;
		end else begin
			frame_vld <= 1'b0;
			if (rx_vld) begin
				case (state)
					R_HUNT: if (is_mark)
						state <= R_OPEN;
					R_OPEN: begin
						if (is_mark) begin
							// fresh frame, stale bytes cleared
							rx_frame <= '0;
							state <= R_PAYLOAD;
						end else begin
							state <= R_HUNT;
						end
					end
					R_PAYLOAD: begin
						if (is_mark) begin
							state <= R_CLOSE;
						end else if (buf_full) begin
							// counted, not stored
							rx_frame.overflow <= 1'b1;
						end else begin
							rx_frame.data[rx_frame.len[3:0]] <= rx_byte;
							rx_frame.len <= rx_frame.len + 5'd1;
						end
					end
					R_CLOSE: begin
						// second marker ends it, anything else is a broken frame
						state <= R_HUNT;
						if (is_mark)
							frame_vld <= 1'b1;
					end
					default: state <= R_HUNT;
				endcase
			end
		end
	end

endmodule

// File: source/frame_sender.sv
`timescale 1ns/1ps
/*
 * sends "&&", job.len payload bytes, "&&" through the byte transmitter
 * expects 1 <= len <= 16, the start check lives in the register block
 * job is latched at tx_start, so buffer writes during a frame are harmless
 */
module frame_sender import str_link_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_n,
	input tx_job_t tx_job,
	input logic tx_start,
	output logic tx_busy,
	output logic [7:0] byte_data,
	output logic byte_req,
	input logic byte_done
);

	// one-hot, each state waits for its own byte to finish
	localparam logic [5:0] S_IDLE = 6'b000001;
	localparam logic [5:0] S_MARK1 = 6'b000010;
	localparam logic [5:0] S_MARK2 = 6'b000100;
	localparam logic [5:0] S_PAYLOAD = 6'b001000;
	localparam logic [5:0] S_MARK3 = 6'b010000;
	localparam logic [5:0] S_MARK4 = 6'b100000;

	logic [5:0] state;
	tx_job_t job_q;
	str_len_t byte_idx;

	assign tx_busy = (state != S_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			job_q <= '0;
			byte_idx <= '0;
			byte_data <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				S_IDLE: if (tx_start) begin
					job_q <= tx_job;
					byte_data <= FRAME_MARK;
					byte_req <= 1'b1;
					state <= S_MARK1;
				end
				S_MARK1: if (byte_done) begin
					byte_data <= FRAME_MARK;
					byte_req <= 1'b1;
					state <= S_MARK2;
				end
				S_MARK2: if (byte_done) begin
					byte_data <= job_q.data[0];
					byte_idx <= 5'd1;
					byte_req <= 1'b1;
					state <= S_PAYLOAD;
				end
				S_PAYLOAD: if (byte_done) begin
					byte_req <= 1'b1;
					// byte_idx counts bytes already handed out
					if (byte_idx == job_q.len) begin
						byte_data <= FRAME_MARK;
						state <= S_MARK3;
					end else begin
						byte_data <= job_q.data[byte_idx[3:0]];
						byte_idx <= byte_idx + 5'd1;
					end
				end
				S_MARK3: if (byte_done) begin
					byte_data <= FRAME_MARK;
					byte_req <= 1'b1;
					state <= S_MARK4;
				end
				S_MARK4: if (byte_done)
					state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: source/str_link_pkg.sv
/*
 * shared types for the string link
 * payload bytes must never equal FRAME_MARK, no escaping is done
 * byte 0 of a buffer is the first byte on the line
 */
package str_link_pkg;

	// payload capacity in bytes
	localparam int STR_MAX_BYTES = 16;

	// "&", sent twice before and twice after the payload
	localparam logic [7:0] FRAME_MARK = 8'h26;

	typedef logic [STR_MAX_BYTES-1:0][7:0] str_buf_t;

	// 0 to 16
	typedef logic [4:0] str_len_t;

	typedef struct packed {
		str_buf_t data;
		str_len_t len;
	} tx_job_t;

	typedef struct packed {
		str_buf_t data;
		str_len_t len;
		logic overflow;
	} rx_frame_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

// File: source/string_link_top.sv
`timescale 1ns/1ps
/*
 * string link over a UART, host access through APB
 * CLKS_PER_BIT sets the bit period for both directions
 */
module string_link_top import str_link_pkg::*; #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input apb_req_t apb,
	output apb_rsp_t apb_rsp,
	input logic uart_rx_port,
	output logic uart_tx_port
);

	// transmit path
	tx_job_t tx_job;
	logic tx_start;
	logic tx_busy;
	logic [7:0] byte_data;
	logic byte_req;
	logic byte_done;

	// receive path
	logic [7:0] rx_byte;
	logic rx_vld;
	rx_frame_t rx_frame;
	logic frame_vld;

	apb_string_regs u_regs (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.apb(apb),
		.apb_rsp(apb_rsp),
		.tx_job(tx_job),
		.tx_start(tx_start),
		.tx_busy(tx_busy),
		.rx_frame(rx_frame),
		.frame_vld(frame_vld)
	);

	frame_sender u_sender (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_job(tx_job),
		.tx_start(tx_start),
		.tx_busy(tx_busy),
		.byte_data(byte_data),
		.byte_req(byte_req),
		.byte_done(byte_done)
	);

	uart_byte_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_byte_tx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.byte_data(byte_data),
		.byte_req(byte_req),
		.byte_done(byte_done),
		.uart_tx_port(uart_tx_port)
	);

	uart_byte_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_byte_rx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.uart_rx_port(uart_rx_port),
		.rx_byte(rx_byte),
		.rx_vld(rx_vld)
	);

	frame_receiver u_receiver (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.rx_byte(rx_byte),
		.rx_vld(rx_vld),
		.rx_frame(rx_frame),
		.frame_vld(frame_vld)
	);

endmodule

// File: source/uart_byte_rx.sv
`timescale 1ns/1ps
/*
 * 8N1 byte receiver with a two-flop input synchronizer
 * rx_vld pulses at mid stop bit, bytes with a low stop bit are dropped
 * no back-pressure, the consumer has to take every byte
 */
module uart_byte_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic uart_rx_port,
	output logic [7:0] rx_byte,
	output logic rx_vld
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;

	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic [1:0] state;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [7:0] rx_shift;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			rx_shift <= '0;
			rx_byte <= '0;
			rx_vld <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				ST_IDLE: begin
					baud_cnt <= '0;
					bit_cnt <= '0;
					// falling edge opens a start bit
					if (rx_last && !rx_sync)
						state <= ST_START;
				end
				ST_START: begin
					if (baud_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
						baud_cnt <= '0;
						// glitch if the line is already high again
						state <= rx_sync ? ST_IDLE : ST_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				ST_DATA: begin
					if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
						baud_cnt <= '0;
						if (bit_cnt == 4'd8) begin
							state <= ST_IDLE;
							if (rx_sync) begin
								rx_byte <= rx_shift;
								rx_vld <= 1'b1;
							end
						end else begin
							// lsb first
							rx_shift <= {rx_sync, rx_shift[7:1]};
							bit_cnt <= bit_cnt + 4'd1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: source/uart_byte_tx.sv
`timescale 1ns/1ps
/*
 * 8N1 byte transmitter, CLKS_PER_BIT must be 2 or more
 * byte_done comes exactly 10 bit periods after byte_req
 * a request while busy is ignored
 */
module uart_byte_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic [7:0] byte_data,
	input logic byte_req,
	output logic byte_done,
	output logic uart_tx_port
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic busy;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [8:0] tx_shift;
	logic bit_end;

	assign bit_end = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// last cycle of the stop bit
	assign byte_done = busy & bit_end & (bit_cnt == 4'd9);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			tx_shift <= '0;
			uart_tx_port <= 1'b1;
		end else if (!busy) begin
			baud_cnt <= '0;
			if (byte_req) begin
				busy <= 1'b1;
				bit_cnt <= '0;
				// stop bit rides above the data
				tx_shift <= {1'b1, byte_data};
				uart_tx_port <= 1'b0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
				uart_tx_port <= 1'b1;
			end else begin
				uart_tx_port <= tx_shift[0];
				tx_shift <= {1'b1, tx_shift[8:1]};
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

endmodule

// File: src.f
source/str_link_pkg.sv
source/uart_byte_tx.sv
source/uart_byte_rx.sv
source/frame_sender.sv
source/frame_receiver.sv
source/apb_string_regs.sv
source/string_link_top.sv
tests/tb_string_link.sv

// File: tests/tb_string_link.sv
`timescale 1ns/1ps
/*
 * self-checking testbench for string_link_top, 8 clocks per UART bit
 * serial input comes from loopback or from a bit-bang driver
 * payload bytes are never 0x26, the run stops at the first mismatch
 */
module tb_string_link import str_link_pkg::*;;

	localparam int CLKS = 8;
	// 8 frames of 24 bytes at 80 cycles per byte is about 15k, plus margin
	localparam int TIMEOUT_CYCLES = 60000;
	localparam int FRAME_CYCLES = 24 * 10 * CLKS;
	localparam logic [7:0] A_CTRL = 8'h00;
	localparam logic [7:0] A_STATUS = 8'h04;
	localparam logic [7:0] A_ACK = 8'h08;
	localparam logic [7:0] A_TXD = 8'h10;
	localparam logic [7:0] A_RXD = 8'h20;

	typedef logic [7:0] byte_q_t[$];

	logic sys_clk;
	logic sys_rst_n;
	apb_req_t apb;
	apb_rsp_t apb_rsp;
	wire uart_rx_port;
	logic uart_tx_port;
	logic loopback;
	logic bang_line;
	int cycle_cnt;

	byte_q_t pay;
	byte_q_t junk;
	byte_q_t line;
	byte_q_t line2;
	logic [31:0] rd;
	logic err;

	// serial source select
	assign uart_rx_port = loopback ? uart_tx_port : bang_line;

	string_link_top #(
		.CLKS_PER_BIT(CLKS)
	) u_string_link_top (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.apb(apb),
		.apb_rsp(apb_rsp),
		.uart_rx_port(uart_rx_port),
		.uart_tx_port(uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout, the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "run aborted on timeout");
		end
	end

	task automatic check(input string name, input logic [31:0] expv, input logic [31:0] act);
		if (expv !== act) begin
			$display("ERR %s expected %0h actual %0h", name, expv, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		#1;
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = 1'b1;
		apb.paddr = addr;
		apb.pwdata = data;
		@(posedge sys_clk);
		#1;
		apb.penable = 1'b1;
		@(posedge sys_clk);
		#1;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
		apb.pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
		@(posedge sys_clk);
		#1;
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = 1'b0;
		apb.paddr = addr;
		@(posedge sys_clk);
		#1;
		apb.penable = 1'b1;
		// mid access phase, away from the edge
		@(negedge sys_clk);
		data = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		// zero wait states
		check("apb pready", 32'd1, {31'd0, apb_rsp.pready});
		@(posedge sys_clk);
		#1;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic wait_status(input int bit_idx, input logic val);
		logic [31:0] d;
		logic e;
		apb_read(A_STATUS, d, e);
		while (d[bit_idx] !== val)
			apb_read(A_STATUS, d, e);
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = {24'd0, FRAME_MARK};
		while (r[7:0] == FRAME_MARK)
			r = $urandom;
		return r[7:0];
	endfunction

	function automatic byte_q_t random_payload(input int n);
		byte_q_t q;
		for (int i = 0; i < n; i++)
			q.push_back(rand_byte());
		return q;
	endfunction

	// "&&" payload "&&" appended to a line
	function automatic byte_q_t add_frame(input byte_q_t head, input byte_q_t p);
		byte_q_t q;
		q = head;
		q.push_back(FRAME_MARK);
		q.push_back(FRAME_MARK);
		for (int i = 0; i < p.size(); i++)
			q.push_back(p[i]);
		q.push_back(FRAME_MARK);
		q.push_back(FRAME_MARK);
		return q;
	endfunction

	// expected frame: first complete frame found in a line byte stream
	function automatic rx_frame_t ref_frame(input byte_q_t bytes);
		rx_frame_t cur;
		rx_frame_t result;
		int st;
		bit found;
		cur = '0;
		result = '0;
		st = 0;
		found = 1'b0;
		for (int i = 0; i < bytes.size(); i++) begin
			if (!found) begin
				if (st == 0) begin
					if (bytes[i] == FRAME_MARK)
						st = 1;
				end else if (st == 1) begin
					st = (bytes[i] == FRAME_MARK) ? 2 : 0;
					cur = '0;
				end else if (st == 2) begin
					if (bytes[i] == FRAME_MARK)
						st = 3;
					else if (cur.len == 5'd16)
						cur.overflow = 1'b1;
					else begin
						cur.data[cur.len[3:0]] = bytes[i];
						cur.len = cur.len + 5'd1;
					end
				end else begin
					// lone marker in payload breaks the frame
					st = 0;
					if (bytes[i] == FRAME_MARK) begin
						result = cur;
						found = 1'b1;
					end
				end
			end
		end
		return result;
	endfunction

	task automatic load_tx(input byte_q_t p);
		logic [31:0] w;
		for (int i = 0; i < 4; i++) begin
			w = '0;
			for (int k = 0; k < 4; k++)
				if (4 * i + k < p.size())
					w[8*k +: 8] = p[4 * i + k];
			apb_write(A_TXD + 8'(4 * i), w);
		end
	endtask

	task automatic bang_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			#1;
			bang_line = bits[i];
			repeat (CLKS - 1) @(posedge sys_clk);
		end
	endtask

	task automatic bang_line_bytes(input byte_q_t q);
		for (int i = 0; i < q.size(); i++)
			bang_byte(q[i]);
	endtask

	task automatic check_frame(input string name, input rx_frame_t e, input logic dropped);
		logic [31:0] d;
		logic se;
		logic [31:0] w;
		apb_read(A_STATUS, d, se);
		check({name, " rx_ready"}, 32'd1, {31'd0, d[1]});
		check({name, " overflow"}, {31'd0, e.overflow}, {31'd0, d[2]});
		check({name, " dropped"}, {31'd0, dropped}, {31'd0, d[3]});
		check({name, " rx_len"}, {27'd0, e.len}, {27'd0, d[12:8]});
		for (int i = 0; i < 4; i++) begin
			w = {e.data[4*i+3], e.data[4*i+2], e.data[4*i+1], e.data[4*i]};
			apb_read(A_RXD + 8'(4 * i), d, se);
			check({name, " rx_data"}, w, d);
		end
	endtask

	task automatic ack_and_check(input string name);
		logic [31:0] d;
		logic se;
		apb_write(A_ACK, 32'd1);
		apb_read(A_STATUS, d, se);
		check({name, " ack clears flags"}, 32'd0, d & 32'h0000_000a);
	endtask

	initial begin
		void'($urandom(92));
		cycle_cnt = 0;
		loopback = 1'b1;
		bang_line = 1'b1;
		apb = '0;
		sys_rst_n = 1'b0;
		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		// reset state and unmapped access
		apb_read(A_STATUS, rd, err);
		check("reset status", 32'd0, rd);
		check("reset tx line", 32'd1, {31'd0, uart_tx_port});
		apb_read(8'h40, rd, err);
		check("unmapped pslverr", 32'd1, {31'd0, err});
		check("unmapped data", 32'd0, rd);

		// loopback of a random frame
		pay = random_payload(($urandom % 16) + 1);
		load_tx(pay);
		apb_write(A_CTRL, 32'h100 | pay.size());
		apb_read(A_STATUS, rd, err);
		check("loop tx_busy", 32'd1, {31'd0, rd[0]});
		wait_status(1, 1'b1);
		check_frame("loop", ref_frame(add_frame(junk, pay)), 1'b0);
		apb_read(A_STATUS, rd, err);
		check("loop tx idle", 32'd0, {31'd0, rd[0]});
		ack_and_check("loop");

		// zero length start and a start while busy are ignored
		apb_write(A_CTRL, 32'h100);
		apb_read(A_STATUS, rd, err);
		check("len0 tx_busy", 32'd0, {31'd0, rd[0]});
		pay = random_payload(($urandom % 16) + 1);
		load_tx(pay);
		apb_write(A_CTRL, 32'h100 | pay.size());
		// buffer rewrite mid frame must not reach the line
		load_tx(random_payload(16));
		apb_write(A_CTRL, 32'h110);
		wait_status(1, 1'b1);
		wait_status(0, 1'b0);
		check_frame("busy start", ref_frame(add_frame(junk, pay)), 1'b0);
		ack_and_check("busy start");
		repeat (FRAME_CYCLES) @(posedge sys_clk);
		apb_read(A_STATUS, rd, err);
		check("single frame", 32'd0, rd & 32'h0000_000b);

		// junk, a lone marker, then a real frame
		loopback = 1'b0;
		junk = random_payload(3);
		junk.push_back(FRAME_MARK);
		junk.push_back(rand_byte());
		pay = random_payload(($urandom % 16) + 1);
		line = add_frame(junk, pay);
		bang_line_bytes(line);
		wait_status(1, 1'b1);
		check_frame("junk", ref_frame(line), 1'b0);
		ack_and_check("junk");

		// 20 byte payload overflows
		junk.delete();
		line = add_frame(junk, random_payload(20));
		bang_line_bytes(line);
		wait_status(1, 1'b1);
		check_frame("overflow", ref_frame(line), 1'b0);
		ack_and_check("overflow");

		// second frame without ack is dropped
		line = add_frame(junk, random_payload(($urandom % 16) + 1));
		line2 = add_frame(line, random_payload(($urandom % 16) + 1));
		bang_line_bytes(line2);
		wait_status(3, 1'b1);
		check_frame("drop", ref_frame(line), 1'b1);
		ack_and_check("drop");

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
